/* Bender.yml */
package:
  name: ialu

sources:
  - files:
      - source/ialu_pkg.sv
      - source/ialu_main_adder.sv
      - source/ialu_bitwise.sv
      - source/ialu_div_ctrl.sv
      - source/ialu_div_datapath.sv
      - source/ialu_result_mux.sv
      - source/ialu_top.sv
  - target: test
    files:
      - dv/ialu_checker.sv
      - dv/ialu_tb.sv

/* all.f */
source/ialu_pkg.sv
source/ialu_main_adder.sv
source/ialu_bitwise.sv
source/ialu_div_ctrl.sv
source/ialu_div_datapath.sv
source/ialu_result_mux.sv
source/ialu_top.sv
dv/ialu_checker.sv
dv/ialu_tb.sv

/* dv/ialu_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module ialu_div_checker import ialu_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic            cmd_vd_i,
    input div_state_e      state_i,
    input logic            iter_rdy_i,
    input logic            res_rdy_i,
    input logic [xlen-1:0] cnt_i         // One-hot iteration counter
);

//--------------------------------------------------
// Sequencer transitions
//--------------------------------------------------
a_corr_to_idle : assert property (@(posedge clk) disable iff (!rst_n)
    state_i == div_corr |=> state_i == div_idle)
    else $error("CORR state not followed by IDLE");

// Requester holds valid while iterating
a_iter_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == div_iter && !iter_rdy_i && cmd_vd_i) |=> state_i == div_iter)
    else $error("ITER left before the last iteration");

a_idle_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == div_idle && !cmd_vd_i) |=> state_i == div_idle)
    else $error("IDLE left without a division request");

//--------------------------------------------------
// Ready and counter
//--------------------------------------------------
a_rdy_no_cmd : assert property (@(posedge clk) disable iff (!rst_n)
    !cmd_vd_i |-> res_rdy_i)
    else $error("res_rdy_o low with no division pending");

// First ITER cycle sees the counter start value
a_cnt_load : assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == div_idle ##1 state_i == div_iter) |-> cnt_i == div_cnt_init)
    else $error("Iteration counter not loaded on ITER entry");

endmodule : ialu_div_checker

bind ialu_div_ctrl ialu_div_checker u_div_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vd_i   (cmd_vd_i),
    .state_i    (state_o),
    .iter_rdy_i (iter_rdy_o),
    .res_rdy_i  (res_rdy_o),
    .cnt_i      (cnt)
);

`default_nettype wire

/* dv/ialu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module ialu_tb import ialu_pkg::*; ();

localparam int clk_period = 8;
localparam int n_rand     = 16;          // Random pairs per command
localparam int n_bnd      = 6;           // Boundary pairs
localparam int n_div_rand = 6;           // Per sign combination and command
localparam int n_b2b      = 8;           // Back-to-back divisions
localparam int wait_max   = 40;          // Cycles allowed per division wait
// Operation count for sizing the watchdog
localparam int n_ops = 5 * (n_bnd + n_rand) + 6 * (2 * n_bnd + n_rand + 2)
                     + 3 * 32 + 4 * 4 * n_div_rand + 4 * 4 + n_b2b;

logic            clk = 1'b0;
logic            rst_n;
logic            cmd_vd_i;
ialu_cmd_e       cmd_i;
logic [xlen-1:0] op1_i;
logic [xlen-1:0] op2_i;
logic [xlen-1:0] res_o;
logic            cmp_o;
logic            res_rdy_o;
int              seed = 99227;

// Sign and carry boundaries
logic [xlen-1:0] bnd_a [n_bnd] = '{32'h0, 32'hffff_ffff, 32'h7fff_ffff,
                                   32'h8000_0000, 32'h8000_0000, 32'h1};
logic [xlen-1:0] bnd_b [n_bnd] = '{32'h0, 32'h1, 32'h1,
                                   32'hffff_ffff, 32'h8000_0000, 32'hffff_ffff};
ialu_cmd_e       div_ops [4] = '{ialu_div, ialu_divu, ialu_rem, ialu_remu};

always #(clk_period / 2) clk = ~clk;

ialu_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_vd_i  (cmd_vd_i),
    .cmd_i     (cmd_i),
    .op1_i     (op1_i),
    .op2_i     (op2_i),
    .res_o     (res_o),
    .cmp_o     (cmp_o),
    .res_rdy_o (res_rdy_o)
);

//--------------------------------------------------
// Reference model
//--------------------------------------------------
function automatic logic ref_cmp(ialu_cmd_e c, logic [xlen-1:0] a, logic [xlen-1:0] b);
    case (c)
        ialu_sub_lt  : return $signed(a) < $signed(b);
        ialu_sub_ltu : return a < b;
        ialu_sub_eq  : return a == b;
        ialu_sub_ne  : return a != b;
        ialu_sub_ge  : return $signed(a) >= $signed(b);
        ialu_sub_geu : return a >= b;
        default      : return 1'b0;     // Not a compare
    endcase
endfunction

// Truncating division with the remainder following the dividend sign
function automatic logic [xlen-1:0] ref_div(ialu_cmd_e c, logic [xlen-1:0] a,
                                            logic [xlen-1:0] b);
    logic signed [xlen-1:0] sa;
    logic signed [xlen-1:0] sb;
    logic                   is_rem;
    sa     = a;
    sb     = b;
    is_rem = (c == ialu_rem) || (c == ialu_remu);
    if (b == '0) return is_rem ? a : '1;                     // By zero
    if (c == ialu_divu) return a / b;
    if (c == ialu_remu) return a % b;
    if (a == 32'h8000_0000 && b == '1) return is_rem ? '0 : a;   // Signed overflow
    if (is_rem) return sa % sb;
    return sa / sb;
endfunction

function automatic logic [xlen-1:0] ref_res(ialu_cmd_e c, logic [xlen-1:0] a,
                                            logic [xlen-1:0] b);
    case (c)
        ialu_add : return a + b;
        ialu_sub : return a - b;
        ialu_and : return a & b;
        ialu_or  : return a | b;
        ialu_xor : return a ^ b;
        ialu_sll : return a << b[shamt_w-1:0];
        ialu_srl : return a >> b[shamt_w-1:0];
        ialu_sra : return $signed(a) >>> b[shamt_w-1:0];
        ialu_div, ialu_divu, ialu_rem, ialu_remu : return ref_div(c, a, b);
        default  : return xlen'(ref_cmp(c, a, b));            // Compare bit zero extended
    endcase
endfunction

//--------------------------------------------------
// Drive and check helpers
//--------------------------------------------------
task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on first error");
endtask

task automatic compare_value(input string tname, input logic [xlen-1:0] exp_v,
                             input logic [xlen-1:0] act_v);
    if (act_v !== exp_v) begin
        $display("** Error: %s expected %h actual %h", tname, exp_v, act_v);
        abort_run("Result mismatch, run stopped");
    end
endtask

// Zero latency command sampled at the falling edge
task automatic run_comb(input string tname, input ialu_cmd_e c,
                        input logic [xlen-1:0] a, input logic [xlen-1:0] b);
    string id;
    int    vd;
    vd = $random(seed);
    @(posedge clk);
    cmd_vd_i <= vd[0];                   // Non-division commands ignore valid
    cmd_i    <= c;
    op1_i    <= a;
    op2_i    <= b;
    @(negedge clk);
    id = $sformatf("%s %s %h,%h", tname, c.name(), a, b);
    compare_value({id, " res"}, ref_res(c, a, b), res_o);
    compare_value({id, " cmp"}, xlen'(ref_cmp(c, a, b)), xlen'(cmp_o));
    compare_value({id, " rdy"}, xlen'(1), xlen'(res_rdy_o));   // Never busy
endtask

// Division handshake where hold keeps valid up for the next request
task automatic run_div(input string tname, input ialu_cmd_e c, input logic [xlen-1:0] a,
                       input logic [xlen-1:0] b, input bit hold);
    int    cyc;
    string id;
    @(posedge clk);
    cmd_vd_i <= 1'b1;
    cmd_i    <= c;
    op1_i    <= a;
    op2_i    <= b;
    id  = $sformatf("%s %s %h,%h", tname, c.name(), a, b);
    cyc = 0;
    @(negedge clk);
    while (res_rdy_o !== 1'b1) begin
        if (cyc == wait_max) abort_run({id, ": res_rdy_o did not rise within 40 cycles"});
        cyc++;
        @(negedge clk);
    end
    if (cyc > 33) abort_run($sformatf("%s: division took %0d cycles, limit is 33", id, cyc));
    compare_value(id, ref_div(c, a, b), res_o);
    if (!hold) begin
        @(posedge clk);
        cmd_vd_i <= 1'b0;
        cmd_i    <= ialu_none;
    end
endtask

//--------------------------------------------------
// Directed tests
//--------------------------------------------------
task automatic test_arith();
    ialu_cmd_e ops [5] = '{ialu_add, ialu_sub, ialu_and, ialu_or, ialu_xor};
    foreach (ops[i]) begin
        for (int k = 0; k < n_bnd; k++) run_comb("arith", ops[i], bnd_a[k], bnd_b[k]);
        repeat (n_rand) run_comb("arith", ops[i], $random(seed), $random(seed));
    end
endtask

task automatic test_compare();
    ialu_cmd_e       ops [6] = '{ialu_sub_lt, ialu_sub_ltu, ialu_sub_eq,
                                 ialu_sub_ne, ialu_sub_ge, ialu_sub_geu};
    logic [xlen-1:0] a;
    foreach (ops[i]) begin
        for (int k = 0; k < n_bnd; k++) begin
            run_comb("compare", ops[i], bnd_a[k], bnd_b[k]);
            run_comb("compare", ops[i], bnd_b[k], bnd_a[k]);     // Swapped order
        end
        a = $random(seed);
        run_comb("compare", ops[i], a, a);                       // Equal operands
        run_comb("compare", ops[i], 32'h8000_0000, 32'h8000_0000);
        repeat (n_rand) run_comb("compare", ops[i], $random(seed), $random(seed));
    end
endtask

task automatic test_shift();
    ialu_cmd_e       ops [3] = '{ialu_sll, ialu_srl, ialu_sra};
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    foreach (ops[i]) begin
        for (int sh = 0; sh < 32; sh++) begin
            a = $random(seed);
            a[xlen-1] = sh[0];                   // Both signs for SRA
            b = $random(seed);                   // Junk in the upper bits
            b[shamt_w-1:0] = sh[shamt_w-1:0];
            run_comb("shift", ops[i], a, b);
        end
    end
endtask

task automatic test_div_random();
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    int              sh;
    foreach (div_ops[i]) begin
        for (int k = 0; k < 4; k++) begin        // Sign combinations
            repeat (n_div_rand) begin
                sh = $random(seed) & 31;
                a  = $random(seed) & 32'h7fff_ffff;
                b  = ($random(seed) & 32'h7fff_ffff) >> sh;   // Varied quotient size
                if (k[1]) a = -a;
                if (k[0]) b = -b;
                run_div("div_random", div_ops[i], a, b, 1'b0);
            end
        end
    end
endtask

task automatic test_div_corner();
    foreach (div_ops[i]) begin
        run_div("div_by_zero", div_ops[i], $random(seed), 32'h0, 1'b0);
        run_div("div_zero_dividend", div_ops[i], 32'h0, $random(seed) | 32'h1, 1'b0);
        run_div("div_min_by_m1", div_ops[i], 32'h8000_0000, 32'hffff_ffff, 1'b0);
        run_div("div_zero_by_zero", div_ops[i], 32'h0, 32'h0, 1'b0);
    end
endtask

task automatic test_div_b2b();
    ialu_cmd_e c;
    for (int i = 0; i < n_b2b; i++) begin
        c = div_ops[$unsigned($random(seed)) % 4];
        run_div("div_b2b", c, $random(seed), $random(seed), i != n_b2b - 1);
    end
endtask

//--------------------------------------------------
// Main sequence and watchdog
//--------------------------------------------------
initial begin : main
    cmd_vd_i = 1'b0;
    cmd_i    = ialu_none;
    op1_i    = '0;
    op2_i    = '0;
    rst_n    = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    test_arith();
    test_compare();
    test_shift();
    test_div_random();
    test_div_corner();
    test_div_b2b();
    @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
end

initial begin : watchdog
    #(n_ops * wait_max * clk_period + 100 * clk_period);
    abort_run("Watchdog expired, tests did not finish in time");
end

endmodule : ialu_tb

`default_nettype wire

/* source/ialu_bitwise.sv */
`timescale 1ns/10ps
`default_nettype none

module ialu_bitwise import ialu_pkg::*; (
    input  ialu_cmd_e       cmd_i,
    input  logic [xlen-1:0] op1_i,
    input  logic [xlen-1:0] op2_i,
    output logic [xlen-1:0] bit_res_o
);

logic [shamt_w-1:0] shamt;               // Only low bits of op2 count

assign shamt = op2_i[shamt_w-1:0];

//------------------------------------------------
// Logic ops and barrel shifter
//------------------------------------------------
always_comb begin
    bit_res_o = '0;
    case (cmd_i)
        ialu_and : bit_res_o = op1_i & op2_i;
        ialu_or  : bit_res_o = op1_i | op2_i;
        ialu_xor : bit_res_o = op1_i ^ op2_i;
        ialu_sll : bit_res_o = op1_i << shamt;
        ialu_srl : bit_res_o = op1_i >> shamt;               // Zero fill
        ialu_sra : bit_res_o = $signed(op1_i) >>> shamt;     // Sign fill
        default  : bit_res_o = '0;
    endcase
end

endmodule : ialu_bitwise

`default_nettype wire

/* source/ialu_div_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module ialu_div_ctrl import ialu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_vd_i,
    input  ialu_cmd_e       cmd_i,
    input  logic [xlen-1:0] op1_i,
    input  logic [xlen-1:0] op2_i,
    input  logic            corr_req_i,
    output div_state_e      state_o,
    output logic            iter_rdy_o,
    output logic            res_rdy_o
);

logic            div_grp;                // DIV, DIVU, REM or REMU
logic            ops_non_zero;
logic            iter_req;               // Start iterating from IDLE
logic            st_idle;
logic            fsm_rdy;                // Ready as seen by the sequencer
logic            cnt_en;
logic [xlen-1:0] cnt;                    // One-hot iteration counter
logic [xlen-1:0] cnt_next;
div_state_e      state_ff;
div_state_e      state_next;

assign div_grp = (cmd_i == ialu_div) | (cmd_i == ialu_divu)
               | (cmd_i == ialu_rem) | (cmd_i == ialu_remu);

assign ops_non_zero = |op1_i & |op2_i;   // Zero operands finish at once
assign st_idle      = (state_ff == div_idle);
assign iter_req     = div_grp & ops_non_zero & st_idle;
assign iter_rdy_o   = cnt[0];

//------------------------------------------------
// Iteration counter
//------------------------------------------------
assign cnt_en   = cmd_vd_i & ~res_rdy_o;
assign cnt_next = ~st_idle ? cnt >> 1
                : div_grp  ? div_cnt_init
                           : cnt;

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        cnt <= '0;
    end else if (cnt_en) begin
        cnt <= cnt_next;
    end
end

//------------------------------------------------
// Sequencer
//------------------------------------------------
always_comb begin
    state_next = div_idle;               // Dropped valid aborts to IDLE
    if (cmd_vd_i) begin
        case (state_ff)
            div_idle : state_next = iter_req ? div_iter : div_idle;
            div_iter : state_next = ~iter_rdy_o ? div_iter
                                  : corr_req_i  ? div_corr
                                                : div_idle;
            default  : state_next = div_idle;
        endcase
    end
end

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        state_ff <= div_idle;
    end else begin
        state_ff <= state_next;
    end
end

assign state_o = state_ff;

// Result ready, high whenever no division is pending
always_comb begin
    case (state_ff)
        div_idle : fsm_rdy = ~iter_req;
        div_iter : fsm_rdy = iter_rdy_o & ~corr_req_i;
        default  : fsm_rdy = 1'b1;       // CORR is one cycle
    endcase
end

assign res_rdy_o = ~(cmd_vd_i & div_grp) | fsm_rdy;

endmodule : ialu_div_ctrl

`default_nettype wire

/* source/ialu_div_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module ialu_div_datapath import ialu_pkg::*; (
    input  logic            clk,
    input  logic            cmd_vd_i,
    input  ialu_cmd_e       cmd_i,
    input  logic [xlen-1:0] op1_i,
    input  logic [xlen-1:0] op2_i,
    input  div_state_e      state_i,
    input  logic            iter_rdy_i,
    input  logic            res_rdy_i,
    output logic [xlen-1:0] rem_o,
    output logic [xlen-1:0] quo_o,
    output logic [xlen-1:0] corr_res_o,
    output logic            corr_req_o
);

logic                 ops_sgn;           // DIV or REM
logic                 cmd_rem;           // REM or REMU
logic                 op1_neg;
logic                 op2_neg;
logic                 diff_sgn;          // Operand signs differ
logic                 st_idle;
logic                 st_corr;
logic                 upd;

// Iteration adder
logic                 sum_sub;
logic                 sum_sgn;
logic [div_sum_w-1:0] sum_op1;
logic [div_sum_w-1:0] sum_op2;
logic [div_sum_w-1:0] sum_res;

logic                 rem_c;
logic                 quo_bit;
logic [xlen-1:0]      dvdnd_lo_next;

// Intermediate result registers
logic                 rem_c_ff;
logic [xlen-1:0]      rem_ff;
logic [xlen-1:0]      quo_ff;
logic [xlen-1:0]      dvdnd_lo_ff;       // Dividend bits still to shift in

assign ops_sgn  = (cmd_i == ialu_div) | (cmd_i == ialu_rem);
assign cmd_rem  = (cmd_i == ialu_rem) | (cmd_i == ialu_remu);
assign op1_neg  = ops_sgn & op1_i[xlen-1];
assign op2_neg  = ops_sgn & op2_i[xlen-1];
assign diff_sgn = op1_i[xlen-1] ^ op2_i[xlen-1];
assign st_idle  = (state_i == div_idle);
assign st_corr  = (state_i == div_corr);

//------------------------------------------------
// Iteration adder, non-restoring step
//------------------------------------------------
assign sum_sgn = st_corr ? op1_neg ^ rem_c_ff
               : st_idle ? 1'b0
                         : ~quo_ff[0];   // Previous quotient bit picks add or sub
assign sum_sub = ~(ops_sgn & diff_sgn) ^ sum_sgn;

assign sum_op1 = st_corr ? {1'b0, rem_ff}
               : st_idle ? {{xlen{op1_neg}}, op1_i[xlen-1]}
                         : {rem_ff, dvdnd_lo_ff[xlen-1]};
assign sum_op2 = {op2_neg, op2_i};       // Sign extended divisor

assign sum_res = sum_sub ? sum_op1 - sum_op2 : sum_op1 + sum_op2;

assign rem_c = sum_res[div_sum_w-1];
assign rem_o = sum_res[xlen-1:0];

assign dvdnd_lo_next = st_corr ? '0
                     : st_idle ? op1_i << 1
                               : dvdnd_lo_ff << 1;

// Negative dividend also sets the bit on exact equality
assign quo_bit = ~(op1_neg ^ rem_c)
               | (op1_neg & ({sum_res, dvdnd_lo_next} == '0));
assign quo_o   = st_idle ? {{(xlen-1){1'b0}}, quo_bit}
                         : {quo_ff[xlen-2:0], quo_bit};

//------------------------------------------------
// Registers, only while a division is pending
//------------------------------------------------
assign upd = cmd_vd_i & ~res_rdy_i;

always_ff @(posedge clk) begin
    if (upd) begin
        rem_c_ff    <= rem_c;
        rem_ff      <= rem_o;
        quo_ff      <= quo_o;
        dvdnd_lo_ff <= dvdnd_lo_next;
    end
end

//------------------------------------------------
// Sign correction
//------------------------------------------------
assign corr_req_o = iter_rdy_i
                  & (((cmd_i == ialu_div) & diff_sgn)                   // Negate quotient
                  |  (cmd_rem & |rem_o & (op1_neg ^ rem_c)));           // Fix remainder sign

assign corr_res_o = cmd_rem ? sum_res[xlen-1:0] : -quo_ff;

endmodule : ialu_div_datapath

`default_nettype wire

/* source/ialu_main_adder.sv */
`timescale 1ns/10ps
`default_nettype none

module ialu_main_adder import ialu_pkg::*; (
    input  ialu_cmd_e       cmd_i,
    input  logic [xlen-1:0] op1_i,
    input  logic [xlen-1:0] op2_i,
    output logic [xlen-1:0] sum_o,
    output ialu_flags_s     flags_o
);

logic            sub;                    // Subtract for all but ADD
logic [xlen:0]   sum_full;               // One extra bit for carry out
logic            op2_sgn_eff;            // Sign of op2 as seen by the adder

//------------------------------------------------
// Add / subtract
//------------------------------------------------
assign sub = (cmd_i != ialu_add);

always_comb begin
    if (sub) begin
        sum_full = {1'b0, op1_i} - {1'b0, op2_i};   // Compares go this way too
    end else begin
        sum_full = {1'b0, op1_i} + {1'b0, op2_i};
    end
end

assign sum_o = sum_full[xlen-1:0];

// Negated operand flips its sign for subtraction
assign op2_sgn_eff = op2_i[xlen-1] ^ sub;

//------------------------------------------------
// Flags
//------------------------------------------------
always_comb begin
    flags_o.z = ~|sum_full[xlen-1:0];
    flags_o.s = sum_full[xlen-1];
    flags_o.c = sum_full[xlen];                      // Borrow on subtract
    // Same sign in, other sign out
    flags_o.o = (op1_i[xlen-1] == op2_sgn_eff)
              & (sum_full[xlen-1] != op1_i[xlen-1]);
end

endmodule : ialu_main_adder

`default_nettype wire

/* source/ialu_pkg.sv */
`default_nettype none

package ialu_pkg;

//------------------------------------------------
// Widths
//------------------------------------------------
localparam int xlen      = 32;           // Data path width
localparam int shamt_w   = 5;            // Shift amount bits taken from op2
localparam int div_sum_w = xlen + 1;     // Iteration adder width, sign included

// One-hot iteration counter start, low bit marks the last ITER cycle
localparam logic [xlen-1:0] div_cnt_init = xlen'(1) << (xlen - 2);

//------------------------------------------------
// Types
//------------------------------------------------
typedef enum logic [4:0] {
    ialu_none,
    ialu_add,
    ialu_sub,
    ialu_sub_lt,                         // Signed less than
    ialu_sub_ltu,                        // Unsigned less than
    ialu_sub_eq,
    ialu_sub_ne,
    ialu_sub_ge,
    ialu_sub_geu,
    ialu_and,
    ialu_or,
    ialu_xor,
    ialu_sll,
    ialu_srl,
    ialu_sra,
    ialu_div,
    ialu_divu,
    ialu_rem,
    ialu_remu
} ialu_cmd_e;

typedef struct packed {
    logic z;                             // Zero
    logic s;                             // Sign
    logic o;                             // Signed overflow
    logic c;                             // Carry / borrow
} ialu_flags_s;

// Divider sequencer
typedef enum logic [1:0] {
    div_idle,
    div_iter,
    div_corr
} div_state_e;

endpackage : ialu_pkg

`default_nettype wire

/* source/ialu_result_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module ialu_result_mux import ialu_pkg::*; (
    input  ialu_cmd_e       cmd_i,
    input  logic [xlen-1:0] op1_i,
    input  logic [xlen-1:0] op2_i,
    input  div_state_e      state_i,
    input  logic [xlen-1:0] sum_i,
    input  ialu_flags_s     flags_i,
    input  logic [xlen-1:0] bit_res_i,
    input  logic [xlen-1:0] rem_i,
    input  logic [xlen-1:0] quo_i,
    input  logic [xlen-1:0] corr_res_i,
    output logic [xlen-1:0] res_o,
    output logic            cmp_o
);

logic cmd_rem;                           // Remainder wanted, not quotient
logic lt;                                // Signed less than

assign cmd_rem = (cmd_i == ialu_rem) | (cmd_i == ialu_remu);
assign lt      = flags_i.s ^ flags_i.o;

//------------------------------------------------
// Compare flag
//------------------------------------------------
always_comb begin
    case (cmd_i)
        ialu_sub_lt  : cmp_o = lt;
        ialu_sub_ltu : cmp_o = flags_i.c;
        ialu_sub_eq  : cmp_o = flags_i.z;
        ialu_sub_ne  : cmp_o = ~flags_i.z;
        ialu_sub_ge  : cmp_o = ~lt;
        ialu_sub_geu : cmp_o = ~flags_i.c;
        default      : cmp_o = 1'b0;
    endcase
end

//------------------------------------------------
// Result word
//------------------------------------------------
always_comb begin
    res_o = '0;
    case (cmd_i)
        ialu_add, ialu_sub : res_o = sum_i;
        ialu_sub_lt, ialu_sub_ltu, ialu_sub_eq,
        ialu_sub_ne, ialu_sub_ge, ialu_sub_geu : res_o = xlen'(cmp_o);   // Zero extended
        ialu_and, ialu_or, ialu_xor,
        ialu_sll, ialu_srl, ialu_sra : res_o = bit_res_i;
        ialu_div, ialu_divu, ialu_rem, ialu_remu : begin
            case (state_i)
                // Immediate cases, by zero gives all ones or the dividend
                div_idle : res_o = (|op2_i | cmd_rem) ? op1_i : '1;
                div_iter : res_o = cmd_rem ? rem_i : quo_i;
                default  : res_o = corr_res_i;
            endcase
        end
        default : res_o = '0;
    endcase
end

endmodule : ialu_result_mux

`default_nettype wire

/* source/ialu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ialu_top import ialu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_vd_i,    // Division command valid
    input  ialu_cmd_e       cmd_i,
    input  logic [xlen-1:0] op1_i,
    input  logic [xlen-1:0] op2_i,
    output logic [xlen-1:0] res_o,
    output logic            cmp_o,
    output logic            res_rdy_o
);

div_state_e      state;
logic            iter_rdy;
logic            corr_req;
logic [xlen-1:0] rem;
logic [xlen-1:0] quo;
logic [xlen-1:0] corr_res;
logic [xlen-1:0] sum;
ialu_flags_s     flags;
logic [xlen-1:0] bit_res;

//------------------------------------------------
// Zero latency units
//------------------------------------------------
ialu_main_adder u_main_adder (
    .cmd_i   (cmd_i),
    .op1_i   (op1_i),
    .op2_i   (op2_i),
    .sum_o   (sum),
    .flags_o (flags)
);

ialu_bitwise u_bitwise (
    .cmd_i     (cmd_i),
    .op1_i     (op1_i),
    .op2_i     (op2_i),
    .bit_res_o (bit_res)
);

//------------------------------------------------
// Divider
//------------------------------------------------
ialu_div_ctrl u_div_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vd_i   (cmd_vd_i),
    .cmd_i      (cmd_i),
    .op1_i      (op1_i),
    .op2_i      (op2_i),
    .corr_req_i (corr_req),
    .state_o    (state),
    .iter_rdy_o (iter_rdy),
    .res_rdy_o  (res_rdy_o)
);

ialu_div_datapath u_div_datapath (
    .clk        (clk),
    .cmd_vd_i   (cmd_vd_i),
    .cmd_i      (cmd_i),
    .op1_i      (op1_i),
    .op2_i      (op2_i),
    .state_i    (state),
    .iter_rdy_i (iter_rdy),
    .res_rdy_i  (res_rdy_o),
    .rem_o      (rem),
    .quo_o      (quo),
    .corr_res_o (corr_res),
    .corr_req_o (corr_req)
);

ialu_result_mux u_result_mux (
    .cmd_i      (cmd_i),
    .op1_i      (op1_i),
    .op2_i      (op2_i),
    .state_i    (state),
    .sum_i      (sum),
    .flags_i    (flags),
    .bit_res_i  (bit_res),
    .rem_i      (rem),
    .quo_i      (quo),
    .corr_res_i (corr_res),
    .res_o      (res_o),
    .cmp_o      (cmp_o)
);

endmodule : ialu_top

`default_nettype wire
